/* all.f */
design/icache_pkg.sv
design/fetch_port_if.sv
design/line_ram.sv
design/way_tags.sv
design/cache_way.sv
design/init_sweep.sv
design/icache_data_array.sv
tb/icache_checker.sv
tb/icache_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and fail if the log shows the fail message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module icache_tb \
  -Mdir obj_dir -o icache_sim > build.log 2>&1 &&
./obj_dir/icache_sim > sim.log 2>&1 &&
cat sim.log &&
! grep -q "RESULT: FAIL" sim.log ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }

/* tb/icache_tb.sv */
// Testbench for the instruction cache data array with a reference model of tags, lines and flags
`timescale 1ns/100ps

module icache_tb import icache_pkg::*; ();

  localparam int NUM_WAYS  = 4;
  localparam int WAY_BITS  = $clog2(NUM_WAYS);
  localparam int MAX_CYCLES = 2000;

  typedef struct packed {
    logic                hit;
    logic [WAY_BITS-1:0] way;
    chunk_flags_t        flags;
    line_t               line;
  } pred_t;

  logic                clk;
  logic                rst;
  logic                invalidate;
  logic                ready;
  logic                rd_a_en;
  logic                rd_a_set_flag;
  fetch_addr_u         rd_a_addr;
  logic                rd_a_hit;
  line_t               rd_a_line;
  chunk_flags_t        rd_a_flags;
  logic                rd_b_en;
  logic                rd_b_set_flag;
  fetch_addr_u         rd_b_addr;
  logic                rd_b_hit;
  line_t               rd_b_line;
  chunk_flags_t        rd_b_flags;
  logic                fill_en;
  fetch_addr_u         fill_addr;
  logic [WAY_BITS-1:0] fill_way;
  line_t               fill_line;

  // Reference model state
  logic [TAG_BITS-1:0] m_tag   [NUM_WAYS][SETS];
  logic                m_valid [NUM_WAYS][SETS];
  line_t               m_line  [NUM_WAYS][SETS];
  chunk_flags_t        m_flags [NUM_WAYS][SETS];
  logic                m_sweep;
  int                  m_cnt;

  pred_t               exp_a;
  pred_t               exp_b;
  logic                exp_valid;
  logic                exp_ready;
  logic                exp_a_mark;
  logic                exp_b_mark;
  fetch_addr_u         exp_a_addr;
  fetch_addr_u         exp_b_addr;
  logic                pend_a;
  logic                pend_b;
  logic [WAY_BITS-1:0] pend_a_way;
  logic [WAY_BITS-1:0] pend_b_way;
  fetch_addr_u         pend_a_addr;
  fetch_addr_u         pend_b_addr;

  integer seed;
  int     n_checks;
  int     n_errors;
  int     cycles;

  icache_data_array #(.NUM_WAYS(NUM_WAYS)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the test did not finish", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [LINE_WIDTH-1:0] got,
                             input logic [LINE_WIDTH-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic pred_t predict_read(input fetch_addr_u addr);
    pred_t p;
    p = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_valid[w][addr.fields.set] && m_tag[w][addr.fields.set] == addr.fields.tag) begin
        p.hit   = 1'b1;
        p.way   = WAY_BITS'(w);
        p.flags = m_flags[w][addr.fields.set];
        p.line  = m_line[w][addr.fields.set];
      end
    end
    return p;
  endfunction

  // Marks of the last cycle land first and a fill of the same line clears them after
  task automatic update_model();
    if (pend_a) m_flags[pend_a_way][pend_a_addr.fields.set][pend_a_addr.fields.chunk] = 1'b1;
    if (pend_b) m_flags[pend_b_way][pend_b_addr.fields.set][pend_b_addr.fields.chunk] = 1'b1;
    if (fill_en && !m_sweep) begin
      m_tag[fill_way][fill_addr.fields.set]   = fill_addr.fields.tag;
      m_valid[fill_way][fill_addr.fields.set] = 1'b1;
      m_line[fill_way][fill_addr.fields.set]  = fill_line;
      m_flags[fill_way][fill_addr.fields.set] = '0;
    end
    if (rst || invalidate) begin
      m_sweep = 1'b1;
      m_cnt   = 0;
      for (int w = 0; w < NUM_WAYS; w++)
        for (int s = 0; s < SETS; s++) m_valid[w][s] = 1'b0;
    end else if (m_sweep) begin
      if (m_cnt == SETS - 1) m_sweep = 1'b0;
      m_cnt++;
    end
    exp_a      = (rd_a_en && !m_sweep) ? predict_read(rd_a_addr) : '0;
    exp_b      = (rd_b_en && !m_sweep) ? predict_read(rd_b_addr) : '0;
    exp_a_mark = rd_a_en && rd_a_set_flag;
    exp_b_mark = rd_b_en && rd_b_set_flag;
    exp_a_addr = rd_a_addr;
    exp_b_addr = rd_b_addr;
    exp_ready  = !m_sweep;
    exp_valid  = 1'b1;
  endtask

  // Outputs are compared mid cycle, well away from both edges
  always @(negedge clk) begin
    if (exp_valid) begin
      check_value("ready", LINE_WIDTH'(ready), LINE_WIDTH'(exp_ready));
      check_value("rd_a_hit", LINE_WIDTH'(rd_a_hit), LINE_WIDTH'(exp_a.hit));
      check_value("rd_a_line", rd_a_line, exp_a.line);
      check_value("rd_a_flags", LINE_WIDTH'(rd_a_flags), LINE_WIDTH'(exp_a.flags));
      check_value("rd_b_hit", LINE_WIDTH'(rd_b_hit), LINE_WIDTH'(exp_b.hit));
      check_value("rd_b_line", rd_b_line, exp_b.line);
      check_value("rd_b_flags", LINE_WIDTH'(rd_b_flags), LINE_WIDTH'(exp_b.flags));
    end
    pend_a      = exp_valid && exp_a.hit && exp_a_mark;
    pend_a_way  = exp_a.way;
    pend_a_addr = exp_a_addr;
    pend_b      = exp_valid && exp_b.hit && exp_b_mark;
    pend_b_way  = exp_b.way;
    pend_b_addr = exp_b_addr;
  end

  task automatic run_cycle();
    @(posedge clk);
    update_model();
    #2;
  endtask

  task automatic clear_inputs();
    rd_a_en       = 1'b0;
    rd_a_set_flag = 1'b0;
    rd_a_addr     = '0;
    rd_b_en       = 1'b0;
    rd_b_set_flag = 1'b0;
    rd_b_addr     = '0;
    fill_en       = 1'b0;
    fill_addr     = '0;
    fill_way      = '0;
    fill_line     = '0;
    invalidate    = 1'b0;
  endtask

  function automatic fetch_addr_u make_addr(input logic [TAG_BITS-1:0] tag, input int s,
                                            input int chunk);
    fetch_addr_u a;
    a.fields.tag   = tag;
    a.fields.set   = set_idx_t'(s);
    a.fields.chunk = CHUNK_BITS'(chunk);
    return a;
  endfunction

  function automatic line_t rand_line();
    line_t l;
    for (int i = 0; i < LINE_WIDTH / 32; i++) l[i*32 +: 32] = $random(seed);
    return l;
  endfunction

  // Small tag pool so that random reads hit often
  function automatic fetch_addr_u rand_addr();
    logic [31:0] r;
    r = $random(seed);
    return make_addr(TAG_BITS'(r[2:0]), int'(r[6:3]), int'(r[8:7]));
  endfunction

  // A tag already present in the set keeps its way, so no two ways ever match
  function automatic logic [WAY_BITS-1:0] pick_way(input fetch_addr_u a,
                                                   input logic [WAY_BITS-1:0] dflt);
    logic [WAY_BITS-1:0] w_sel;
    w_sel = dflt;
    for (int w = 0; w < NUM_WAYS; w++)
      if (m_valid[w][a.fields.set] && m_tag[w][a.fields.set] == a.fields.tag)
        w_sel = WAY_BITS'(w);
    return w_sel;
  endfunction

  task automatic read_both(input fetch_addr_u a, input logic fa, input fetch_addr_u b,
                           input logic fb);
    rd_a_en       = 1'b1;
    rd_a_addr     = a;
    rd_a_set_flag = fa;
    rd_b_en       = 1'b1;
    rd_b_addr     = b;
    rd_b_set_flag = fb;
    run_cycle();
    clear_inputs();
  endtask

  task automatic fill(input fetch_addr_u a, input int w, input line_t l);
    fill_en   = 1'b1;
    fill_addr = a;
    fill_way  = WAY_BITS'(w);
    fill_line = l;
    run_cycle();
    clear_inputs();
  endtask

  task automatic wait_ready();
    while (!ready) run_cycle();
  endtask

  task automatic random_traffic(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      rd_a_en       = r[0];
      rd_a_set_flag = r[1];
      rd_a_addr     = rand_addr();
      rd_b_en       = r[2];
      rd_b_set_flag = r[3];
      rd_b_addr     = rand_addr();
      fill_addr = rand_addr();
      fill_way  = pick_way(fill_addr, WAY_BITS'(r[9:8]));
      fill_line = rand_line();
      fill_en   = (r[5:4] == 2'b00) && fill_addr.fields.set != rd_a_addr.fields.set &&
                  fill_addr.fields.set != rd_b_addr.fields.set;
      run_cycle();
    end
    clear_inputs();
  endtask

  initial begin
    seed      = 32'h4a79_ad41;
    n_checks  = 0;
    n_errors  = 0;
    cycles    = 0;
    exp_valid = 1'b0;
    pend_a    = 1'b0;
    pend_b    = 1'b0;
    m_sweep   = 1'b1;
    m_cnt     = 0;
    clear_inputs();
    rst = 1'b1;
    repeat (4) run_cycle();
    rst = 1'b0;
    for (int i = 0; i < 6; i++) read_both(rand_addr(), 1'b1, rand_addr(), 1'b1);
    wait_ready();

    // Four ways of set 5 with distinct tags
    for (int w = 0; w < NUM_WAYS; w++)
      fill(make_addr(TAG_BITS'(18'h100 + w), 5, 0), w, rand_line());
    for (int w = 0; w < NUM_WAYS; w++)
      read_both(make_addr(TAG_BITS'(18'h100 + w), 5, w % CHUNKS), 1'b0,
                make_addr(TAG_BITS'(18'h100 + w), 5, (w + 1) % CHUNKS), 1'b0);
    read_both(make_addr(18'h3ff, 5, 0), 1'b0, make_addr(18'h100, 6, 0), 1'b0);

    // Both ports mark chunks of one line in the same cycle, then a refill clears them
    read_both(make_addr(18'h101, 5, 1), 1'b1, make_addr(18'h101, 5, 2), 1'b1);
    read_both(make_addr(18'h102, 5, 3), 1'b1, make_addr(18'h101, 5, 0), 1'b0);
    read_both(make_addr(18'h101, 5, 0), 1'b0, make_addr(18'h102, 5, 0), 1'b0);
    fill(make_addr(18'h101, 5, 0), 1, rand_line());
    read_both(make_addr(18'h101, 5, 0), 1'b0, make_addr(18'h102, 5, 0), 1'b0);

    invalidate = 1'b1;
    run_cycle();
    invalidate = 1'b0;
    // Set 5 keeps its valid bits for the first cycles of the sweep and must still miss
    for (int w = 0; w < NUM_WAYS; w++)
      read_both(make_addr(TAG_BITS'(18'h100 + w), 5, 0), 1'b1, make_addr(18'h101, 5, 1), 1'b1);
    fill(make_addr(18'h300, 2, 0), 3, rand_line());   // Dropped while the sweep runs
    wait_ready();
    for (int w = 0; w < NUM_WAYS; w++)
      read_both(make_addr(TAG_BITS'(18'h100 + w), 5, 0), 1'b0, make_addr(18'h300, 2, 0), 1'b0);
    fill(make_addr(18'h200, 9, 0), 2, rand_line());
    read_both(make_addr(18'h200, 9, 3), 1'b1, make_addr(18'h200, 9, 1), 1'b0);

    random_traffic(1000);
    repeat (2) run_cycle();

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tb/icache_checker.sv */
// Concurrent assertions on per-way hits and the ready level of the cache data array
`timescale 1ns/100ps

module icache_checker #(
  parameter int NUM_WAYS = 4
) (
  input logic                clk,
  input logic                rst,
  input logic                invalidate,
  input logic                ready,
  input logic [NUM_WAYS-1:0] way_hit_a,
  input logic [NUM_WAYS-1:0] way_hit_b
);

  // A line lives in one way only
  assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit_a))
    else $error("more than one way hit on port a");

  assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit_b))
    else $error("more than one way hit on port b");

  assert property (@(posedge clk) disable iff (rst)
                   !ready |-> (way_hit_a == '0 && way_hit_b == '0))
    else $error("hit reported while the sweep runs");

  assert property (@(posedge clk) disable iff (rst) (invalidate && ready) |=> !ready)
    else $error("ready stayed high after invalidate");

endmodule

bind icache_data_array icache_checker #(.NUM_WAYS(NUM_WAYS)) u_checker (
  .clk        (clk),
  .rst        (rst),
  .invalidate (invalidate),
  .ready      (ready),
  .way_hit_a  (way_hit_a),
  .way_hit_b  (way_hit_b)
);

/* design/icache_data_array.sv */
// Instruction cache data array with two fetch read ports, one fill port and an init sweep
`timescale 1ns/100ps

module icache_data_array import icache_pkg::*; #(
  parameter  int NUM_WAYS = 4,
  localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                invalidate,
  output logic                ready,

  input  logic                rd_a_en,
  input  fetch_addr_u         rd_a_addr,
  input  logic                rd_a_set_flag,
  output logic                rd_a_hit,
  output line_t               rd_a_line,
  output chunk_flags_t        rd_a_flags,

  input  logic                rd_b_en,
  input  fetch_addr_u         rd_b_addr,
  input  logic                rd_b_set_flag,
  output logic                rd_b_hit,
  output line_t               rd_b_line,
  output chunk_flags_t        rd_b_flags,

  input  logic                fill_en,
  input  fetch_addr_u         fill_addr,
  input  logic [WAY_BITS-1:0] fill_way,
  input  line_t               fill_line
);

  logic                sweep;
  set_idx_t            sweep_set;

  logic [NUM_WAYS-1:0] way_hit_a;
  logic [NUM_WAYS-1:0] way_hit_b;
  line_t               line_a_way  [NUM_WAYS];
  line_t               line_b_way  [NUM_WAYS];
  chunk_flags_t        flags_a_way [NUM_WAYS];
  chunk_flags_t        flags_b_way [NUM_WAYS];

  fetch_port_if port_a_if [NUM_WAYS] ();
  fetch_port_if port_b_if [NUM_WAYS] ();

  init_sweep u_init_sweep (
    .clk        (clk),
    .rst        (rst),
    .invalidate (invalidate),
    .sweep      (sweep),
    .sweep_set  (sweep_set),
    .ready      (ready)
  );

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    // Every way sees the same request
    assign port_a_if[w].en       = rd_a_en;
    assign port_a_if[w].addr     = rd_a_addr;
    assign port_a_if[w].set_flag = rd_a_set_flag;
    assign port_b_if[w].en       = rd_b_en;
    assign port_b_if[w].addr     = rd_b_addr;
    assign port_b_if[w].set_flag = rd_b_set_flag;

    cache_way #(
      .NUM_WAYS  (NUM_WAYS),
      .WAY_INDEX (w)
    ) u_way (
      .clk       (clk),
      .rst       (rst),
      .port_a    (port_a_if[w]),
      .port_b    (port_b_if[w]),
      .sweep     (sweep),
      .sweep_set (sweep_set),
      .fill_en   (fill_en),
      .fill_addr (fill_addr),
      .fill_way  (fill_way),
      .fill_line (fill_line)
    );

    assign way_hit_a[w]   = port_a_if[w].hit;
    assign line_a_way[w]  = port_a_if[w].line;
    assign flags_a_way[w] = port_a_if[w].flags;
    assign way_hit_b[w]   = port_b_if[w].hit;
    assign line_b_way[w]  = port_b_if[w].line;
    assign flags_b_way[w] = port_b_if[w].flags;
  end

  assign rd_a_hit = |way_hit_a;
  assign rd_b_hit = |way_hit_b;

  // Missing ways drive zeros, so a plain OR picks the hitting way
  always_comb begin
    rd_a_line  = '0;
    rd_a_flags = '0;
    rd_b_line  = '0;
    rd_b_flags = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      rd_a_line  = rd_a_line | line_a_way[w];
      rd_a_flags = rd_a_flags | flags_a_way[w];
      rd_b_line  = rd_b_line | line_b_way[w];
      rd_b_flags = rd_b_flags | flags_b_way[w];
    end
  end

endmodule

/* design/init_sweep.sv */
// Set counter that clears every valid bit after reset or invalidate and drives ready
`timescale 1ns/100ps

module init_sweep import icache_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     invalidate,
  output logic     sweep,
  output set_idx_t sweep_set,
  output logic     ready
);

  always_ff @(posedge clk) begin
    if (rst || invalidate) begin
      sweep     <= 1'b1;
      sweep_set <= '0;
    end else if (sweep) begin
      sweep_set <= sweep_set + set_idx_t'(1);   // Wraps back to zero after the last set
      if (sweep_set == set_idx_t'(SETS - 1)) begin
        sweep <= 1'b0;
      end
    end
  end

  // Ready for fetches once the last set has been cleared
  assign ready = !sweep;

endmodule

/* design/cache_way.sv */
// One cache way with line storage, tags, chunk used flags and hit-gated read outputs
`timescale 1ns/100ps

module cache_way import icache_pkg::*; #(
  parameter  int NUM_WAYS  = 4,
  parameter  int WAY_INDEX = 0,
  localparam int WAY_BITS  = $clog2(NUM_WAYS)
) (
  input  logic                clk,
  input  logic                rst,

  fetch_port_if.way           port_a,
  fetch_port_if.way           port_b,

  input  logic                sweep,
  input  set_idx_t            sweep_set,

  input  logic                fill_en,
  input  fetch_addr_u         fill_addr,
  input  logic [WAY_BITS-1:0] fill_way,
  input  line_t               fill_line
);

  logic                  fill_hit;
  logic                  hit_a;
  logic                  hit_b;
  line_t                 ram_line_a;
  line_t                 ram_line_b;

  chunk_flags_t          flags_q [SETS];
  set_idx_t              set_a_q;
  set_idx_t              set_b_q;
  logic [CHUNK_BITS-1:0] chunk_a_q;
  logic [CHUNK_BITS-1:0] chunk_b_q;
  logic                  flag_a_q;
  logic                  flag_b_q;
  logic                  mark_a;
  logic                  mark_b;

  // Fills are ignored until the sweep has finished
  assign fill_hit = fill_en && !sweep && (fill_way == WAY_BITS'(WAY_INDEX));

  line_ram u_line_ram (
    .clk       (clk),
    .rd_a_en   (port_a.en),
    .rd_a_set  (port_a.addr.fields.set),
    .rd_a_line (ram_line_a),
    .rd_b_en   (port_b.en),
    .rd_b_set  (port_b.addr.fields.set),
    .rd_b_line (ram_line_b),
    .wr_en     (fill_hit),
    .wr_set    (fill_addr.fields.set),
    .wr_line   (fill_line)
  );

  way_tags u_way_tags (
    .clk       (clk),
    .rst       (rst),
    .rd_a_en   (port_a.en),
    .rd_a_addr (port_a.addr),
    .rd_b_en   (port_b.en),
    .rd_b_addr (port_b.addr),
    .hit_a     (hit_a),
    .hit_b     (hit_b),
    .sweep     (sweep),
    .sweep_set (sweep_set),
    .wr_en     (fill_hit),
    .wr_addr   (fill_addr)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      flag_a_q <= 1'b0;
      flag_b_q <= 1'b0;
    end else begin
      flag_a_q <= port_a.en && port_a.set_flag;
      flag_b_q <= port_b.en && port_b.set_flag;
    end
  end

  always_ff @(posedge clk) begin
    if (port_a.en) begin
      set_a_q   <= port_a.addr.fields.set;
      chunk_a_q <= port_a.addr.fields.chunk;
    end
    if (port_b.en) begin
      set_b_q   <= port_b.addr.fields.set;
      chunk_b_q <= port_b.addr.fields.chunk;
    end
  end

  // A mark only lands on the line that actually hit
  assign mark_a = flag_a_q && hit_a;
  assign mark_b = flag_b_q && hit_b;

  always_ff @(posedge clk) begin
    if (mark_a) begin
      flags_q[set_a_q][chunk_a_q] <= 1'b1;
    end
    if (mark_b) begin
      flags_q[set_b_q][chunk_b_q] <= 1'b1;
    end
    if (fill_hit) begin
      flags_q[fill_addr.fields.set] <= '0;   // New line starts with no chunk used
    end
  end

  assign port_a.hit   = hit_a;
  assign port_a.line  = hit_a ? ram_line_a : '0;
  assign port_a.flags = hit_a ? flags_q[set_a_q] : '0;

  assign port_b.hit   = hit_b;
  assign port_b.line  = hit_b ? ram_line_b : '0;
  assign port_b.flags = hit_b ? flags_q[set_b_q] : '0;

endmodule

/* design/way_tags.sv */
// Tag and valid store of one way, compared for both fetch ports and cleared by the sweep
`timescale 1ns/100ps

module way_tags import icache_pkg::*; (
  input  logic        clk,
  input  logic        rst,

  input  logic        rd_a_en,
  input  fetch_addr_u rd_a_addr,
  input  logic        rd_b_en,
  input  fetch_addr_u rd_b_addr,
  output logic        hit_a,
  output logic        hit_b,

  input  logic        sweep,
  input  set_idx_t    sweep_set,

  input  logic        wr_en,
  input  fetch_addr_u wr_addr
);

  logic [TAG_BITS-1:0] tag_mem [SETS];
  logic [SETS-1:0]     valid;

  logic                en_a_q;
  logic                en_b_q;
  logic [TAG_BITS-1:0] tag_a_q;
  logic [TAG_BITS-1:0] tag_b_q;
  set_idx_t            set_a_q;
  set_idx_t            set_b_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      en_a_q <= 1'b0;
      en_b_q <= 1'b0;
    end else begin
      en_a_q <= rd_a_en;
      en_b_q <= rd_b_en;
    end
  end

  // Compare inputs held from the last enabled read
  always_ff @(posedge clk) begin
    if (rd_a_en) begin
      tag_a_q <= rd_a_addr.fields.tag;
      set_a_q <= rd_a_addr.fields.set;
    end
    if (rd_b_en) begin
      tag_b_q <= rd_b_addr.fields.tag;
      set_b_q <= rd_b_addr.fields.set;
    end
  end

  always_ff @(posedge clk) begin
    if (sweep) begin
      valid[sweep_set] <= 1'b0;   // One set per cycle
    end else if (wr_en) begin
      valid[wr_addr.fields.set] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_addr.fields.set] <= wr_addr.fields.tag;
    end
  end

  // Nothing hits while the valid bits are being cleared
  assign hit_a = en_a_q && !sweep && valid[set_a_q] && (tag_mem[set_a_q] == tag_a_q);
  assign hit_b = en_b_q && !sweep && valid[set_b_q] && (tag_mem[set_b_q] == tag_b_q);

endmodule

/* design/line_ram.sv */
// Line storage of one way with two registered-address read ports and one write port
`timescale 1ns/100ps

module line_ram import icache_pkg::*; (
  input  logic     clk,

  input  logic     rd_a_en,
  input  set_idx_t rd_a_set,
  output line_t    rd_a_line,

  input  logic     rd_b_en,
  input  set_idx_t rd_b_set,
  output line_t    rd_b_line,

  input  logic     wr_en,
  input  set_idx_t wr_set,
  input  line_t    wr_line
);

  line_t    mem [SETS];
  set_idx_t set_a_q;
  set_idx_t set_b_q;

  // Read addresses only move on their own enable
  always_ff @(posedge clk) begin
    if (rd_a_en) begin
      set_a_q <= rd_a_set;
    end
    if (rd_b_en) begin
      set_b_q <= rd_b_set;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_set] <= wr_line;
    end
  end

  assign rd_a_line = mem[set_a_q];
  assign rd_b_line = mem[set_b_q];

endmodule

/* design/fetch_port_if.sv */
// Fetch read port bundle between the cache top level and one way
`timescale 1ns/100ps

interface fetch_port_if import icache_pkg::*; ();

  logic         en;
  fetch_addr_u  addr;
  logic         set_flag;     // Mark the addressed chunk as used

  logic         hit;
  line_t        line;
  chunk_flags_t flags;

  modport requester (
    output en,
    output addr,
    output set_flag,
    input  hit,
    input  line,
    input  flags
  );

  modport way (
    input  en,
    input  addr,
    input  set_flag,
    output hit,
    output line,
    output flags
  );

endinterface

/* design/icache_pkg.sv */
// Instruction cache data array widths, fetch address layout and line types
package icache_pkg;

  // Fetch address split, tag on top
  localparam int TAG_BITS   = 18;
  localparam int SET_BITS   = 4;
  localparam int CHUNK_BITS = 2;

  localparam int FETCH_ADDR_WIDTH = TAG_BITS + SET_BITS + CHUNK_BITS;

  localparam int SETS = 1 << SET_BITS;

  // A line is CHUNKS fetch chunks side by side
  localparam int CHUNKS      = 1 << CHUNK_BITS;
  localparam int CHUNK_WIDTH = 64;
  localparam int LINE_WIDTH  = CHUNKS * CHUNK_WIDTH;

  typedef logic [SET_BITS-1:0] set_idx_t;

  typedef logic [LINE_WIDTH-1:0] line_t;

  // One used flag per chunk of a line
  typedef logic [CHUNKS-1:0] chunk_flags_t;

  typedef struct packed {
    logic [TAG_BITS-1:0]   tag;
    set_idx_t              set;
    logic [CHUNK_BITS-1:0] chunk;
  } fetch_fields_t;

  // Ports move the raw word, the ways look at the fields
  typedef union packed {
    logic [FETCH_ADDR_WIDTH-1:0] raw;
    fetch_fields_t               fields;
  } fetch_addr_u;

endpackage
